// File: hw/dbg_soc_defs.svh
// Debug subnet identification, layout and packet size macros
`ifndef DBG_SOC_DEFS_SVH
`define DBG_SOC_DEFS_SVH

//////////////////////////////////////////////////
// System identification
//////////////////////////////////////////////////

// Reported by SYS_VENDOR
`define DBG_SYSTEM_VENDOR_ID 16'h0001
// Reported by SYS_DEVICE
`define DBG_SYSTEM_DEVICE_ID 16'h0042
// Modules on this subnet, control module included
`define DBG_NUM_MODULES 16'h0003

//////////////////////////////////////////////////
// Packet and address layout
//////////////////////////////////////////////////

// Largest packet in flits, sizes the host egress store
`define DBG_MAX_PKT_LEN 8
// Upper destination bits holding the subnet number
`define DBG_SUBNET_BITS 6
// Subnet number of this chip
`define DBG_LOCAL_SUBNET 0

`endif

// File: hw/dbg_soc_pkg.sv
// Flit and host word structs, packet type, register address and port enums
package dbg_soc_pkg;

  // One debug flit on a ring or module link
  typedef struct packed {
    logic        valid;
    logic        last;
    logic [15:0] data;
  } dbg_flit_t;

  // One word of the host stream
  typedef struct packed {
    logic        valid;
    logic [15:0] data;
  } host_word_t;

  // Type field in bits 15:12 of the flags flit
  typedef enum logic [3:0] {
    REQ_READ   = 4'h0,
    REQ_WRITE  = 4'h1,
    RESP_READ  = 4'h2,
    RESP_WRITE = 4'h3,
    RESP_ERROR = 4'h4
  } dbg_pkt_type_e;

  // Control module register map
  typedef enum logic [15:0] {
    MOD_VENDOR   = 16'h0000,
    MOD_TYPE     = 16'h0001,
    MOD_VERSION  = 16'h0002,
    SYS_VENDOR   = 16'h0200,
    SYS_DEVICE   = 16'h0201,
    SYS_NUM_MOD  = 16'h0202,
    SYS_MAX_PKT  = 16'h0203,
    SYS_RST_CTRL = 16'h0204
  } dbg_reg_addr_e;

  // Gateway sources, also used as route targets
  typedef enum logic [1:0] {
    PORT_RING  = 2'd0,
    PORT_LOCAL = 2'd1,
    PORT_EXT   = 2'd2
  } dbg_port_e;

endpackage

// File: hw/dbg_pkt_arbiter.sv
// Packet-level round-robin arbiter sharing one flit output
`timescale 1ns/1ps

module dbg_pkt_arbiter #(
  parameter int NUM_IN = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  dbg_soc_pkg::dbg_flit_t in_flit [NUM_IN],
  input  logic                   in_req [NUM_IN],
  output logic                   in_ready [NUM_IN],
  output dbg_soc_pkg::dbg_flit_t out_flit,
  input  logic                   out_ready
);
  import dbg_soc_pkg::*;

  localparam int IW = $clog2(NUM_IN);

  logic [IW-1:0] owner_q;
  logic [IW-1:0] last_q;
  logic [IW-1:0] pick;
  logic [IW-1:0] grant;
  logic          locked_q;
  logic          found;
  logic          xfer;

  // Next requester after the last winner
  always_comb begin
    pick  = last_q;
    found = 1'b0;
    for (int i = 1; i <= NUM_IN; i++) begin
      if (!found && in_req[(int'(last_q) + i) % NUM_IN]) begin
        pick  = IW'((int'(last_q) + i) % NUM_IN);
        found = 1'b1;
      end
    end
  end

  // Open packet keeps its owner
  assign grant = locked_q ? owner_q : pick;

  // Same-cycle pass-through of the granted input
  always_comb begin
    out_flit       = in_flit[grant];
    out_flit.valid = in_req[grant];
    for (int i = 0; i < NUM_IN; i++) begin
      in_ready[i] = (IW'(i) == grant) && in_req[grant] && out_ready;
    end
  end

  assign xfer = out_flit.valid && out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      locked_q <= 1'b0;
      owner_q  <= '0;
      last_q   <= IW'(NUM_IN - 1);
    end else if (xfer) begin
      if (out_flit.last) begin
        // Packet done, rotate from here
        locked_q <= 1'b0;
        last_q   <= grant;
      end else begin
        locked_q <= 1'b1;
        owner_q  <= grant;
      end
    end
  end

  // Source keeps requesting until its packet closes
  a_owner_held: assert property (@(posedge clk) disable iff (!rst_n)
    locked_q |-> in_req[owner_q]);

endmodule

// File: hw/dbg_ring_gateway.sv
// Destination router between ring, control module and host
`timescale 1ns/1ps
`include "dbg_soc_defs.svh"

module dbg_ring_gateway (
  input  logic                   clk,
  input  logic                   rst_n,
  input  dbg_soc_pkg::dbg_flit_t ring_in,
  input  dbg_soc_pkg::dbg_flit_t local_in,
  input  dbg_soc_pkg::dbg_flit_t ext_in,
  output logic                   ring_in_ready,
  output logic                   local_in_ready,
  output logic                   ext_in_ready,
  output dbg_soc_pkg::dbg_flit_t ring_out,
  output dbg_soc_pkg::dbg_flit_t local_out,
  output dbg_soc_pkg::dbg_flit_t ext_out,
  input  logic                   ring_out_ready,
  input  logic                   local_out_ready,
  input  logic                   ext_out_ready
);
  import dbg_soc_pkg::*;

  localparam int LW = 16 - `DBG_SUBNET_BITS;

  dbg_flit_t in_f [3];
  logic      in_rdy [3];
  dbg_port_e rt [3];
  dbg_port_e rt_q [3];
  logic      busy_q [3];

  // Arbiter slots
  dbg_flit_t ring_arb_f [3];
  logic      ring_req [3];
  logic      ring_rdy [3];
  dbg_flit_t loc_arb_f [2];
  logic      loc_req [2];
  logic      loc_rdy [2];
  dbg_flit_t ext_arb_f [2];
  logic      ext_req [2];
  logic      ext_rdy [2];

  // Foreign subnet to host, id 0 to control module, rest around the ring
  // Never route a packet back into the port it came from
  function automatic dbg_port_e route_of(logic [15:0] dest, dbg_port_e src);
    dbg_port_e tgt;
    if (dest[15 -: `DBG_SUBNET_BITS] != `DBG_SUBNET_BITS'(`DBG_LOCAL_SUBNET)) begin
      tgt = PORT_EXT;
    end else if (dest[LW-1:0] == '0) begin
      tgt = PORT_LOCAL;
    end else begin
      tgt = PORT_RING;
    end
    if (tgt == src && src != PORT_RING) begin
      tgt = PORT_RING;
    end
    return tgt;
  endfunction

  assign in_f[PORT_RING]  = ring_in;
  assign in_f[PORT_LOCAL] = local_in;
  assign in_f[PORT_EXT]   = ext_in;

  //////////////////////////////////////////////////
  // Route registers, one per input
  //////////////////////////////////////////////////

  for (genvar g = 0; g < 3; g++) begin : g_route
    // Decode flit 0, then hold until the last flit
    assign rt[g] = busy_q[g] ? rt_q[g] : route_of(in_f[g].data, dbg_port_e'(g));

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        busy_q[g] <= 1'b0;
        rt_q[g]   <= PORT_RING;
      end else if (in_f[g].valid && in_rdy[g]) begin
        busy_q[g] <= !in_f[g].last;
        rt_q[g]   <= rt[g];
      end
    end

    // Ring output takes all three sources in port order
    assign ring_arb_f[g] = in_f[g];
    assign ring_req[g]   = in_f[g].valid && (rt[g] == PORT_RING);
  end

  // Control module fed by ring and host
  assign loc_arb_f[0] = ring_in;
  assign loc_arb_f[1] = ext_in;
  assign loc_req[0]   = ring_in.valid && (rt[PORT_RING] == PORT_LOCAL);
  assign loc_req[1]   = ext_in.valid && (rt[PORT_EXT] == PORT_LOCAL);

  // Host fed by ring and control module
  assign ext_arb_f[0] = ring_in;
  assign ext_arb_f[1] = local_in;
  assign ext_req[0]   = ring_in.valid && (rt[PORT_RING] == PORT_EXT);
  assign ext_req[1]   = local_in.valid && (rt[PORT_LOCAL] == PORT_EXT);

  // Ready from whichever arbiter the route selects
  assign in_rdy[PORT_RING]  = (rt[PORT_RING] == PORT_RING)  ? ring_rdy[0] :
                              (rt[PORT_RING] == PORT_LOCAL) ? loc_rdy[0] : ext_rdy[0];
  assign in_rdy[PORT_LOCAL] = (rt[PORT_LOCAL] == PORT_RING) ? ring_rdy[1] : ext_rdy[1];
  assign in_rdy[PORT_EXT]   = (rt[PORT_EXT] == PORT_RING)   ? ring_rdy[2] : loc_rdy[1];

  assign ring_in_ready  = in_rdy[PORT_RING];
  assign local_in_ready = in_rdy[PORT_LOCAL];
  assign ext_in_ready   = in_rdy[PORT_EXT];

  //////////////////////////////////////////////////
  // Output arbiters
  //////////////////////////////////////////////////

  dbg_pkt_arbiter #(.NUM_IN(3)) i_ring_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_flit   (ring_arb_f),
    .in_req    (ring_req),
    .in_ready  (ring_rdy),
    .out_flit  (ring_out),
    .out_ready (ring_out_ready)
  );

  dbg_pkt_arbiter #(.NUM_IN(2)) i_local_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_flit   (loc_arb_f),
    .in_req    (loc_req),
    .in_ready  (loc_rdy),
    .out_flit  (local_out),
    .out_ready (local_out_ready)
  );

  dbg_pkt_arbiter #(.NUM_IN(2)) i_ext_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_flit   (ext_arb_f),
    .in_req    (ext_req),
    .in_ready  (ext_rdy),
    .out_flit  (ext_out),
    .out_ready (ext_out_ready)
  );

endmodule

// File: hw/dbg_host_if.sv
// Host word stream to flit converter with length-prefixing egress store
`timescale 1ns/1ps
`include "dbg_soc_defs.svh"

module dbg_host_if (
  input  logic                    clk,
  input  logic                    rst_n,
  input  dbg_soc_pkg::host_word_t host_in,
  output logic                    host_in_ready,
  output dbg_soc_pkg::host_word_t host_out,
  input  logic                    host_out_ready,
  output dbg_soc_pkg::dbg_flit_t  ing_flit,
  input  logic                    ing_ready,
  input  dbg_soc_pkg::dbg_flit_t  egr_flit,
  output logic                    egr_ready
);
  import dbg_soc_pkg::*;

  localparam int MAX = `DBG_MAX_PKT_LEN;
  localparam int CW  = $clog2(MAX + 1);
  localparam int AW  = $clog2(MAX);

  typedef enum logic {IDLE, PAYLOAD} ing_state_e;
  typedef enum logic [1:0] {FILL, SEND_LEN, SEND_DATA} egr_state_e;

  ing_state_e ing_q;
  logic [15:0] ing_len_q;
  logic [15:0] ing_cnt_q;

  egr_state_e egr_q;
  logic [CW-1:0] egr_cnt_q;
  logic [AW-1:0] rd_q;
  logic [15:0]   pkt_mem [MAX];

  //////////////////////////////////////////////////
  // Ingress
  //////////////////////////////////////////////////

  // Length word swallowed in IDLE
  assign host_in_ready  = (ing_q == IDLE) ? 1'b1 : ing_ready;
  assign ing_flit.valid = (ing_q == PAYLOAD) && host_in.valid;
  assign ing_flit.data  = host_in.data;
  // Word that completes the count closes the packet
  assign ing_flit.last  = (ing_cnt_q + 16'd1) == ing_len_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ing_q     <= IDLE;
      ing_len_q <= '0;
      ing_cnt_q <= '0;
    end else begin
      case (ing_q)
        IDLE: begin
          if (host_in.valid) begin
            ing_len_q <= host_in.data;
            ing_cnt_q <= '0;
            // Empty packet carries nothing
            if (host_in.data != '0) begin
              ing_q <= PAYLOAD;
            end
          end
        end
        PAYLOAD: begin
          if (ing_flit.valid && ing_ready) begin
            ing_cnt_q <= ing_cnt_q + 16'd1;
            if (ing_flit.last) begin
              ing_q <= IDLE;
            end
          end
        end
        default: ing_q <= IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Egress
  //////////////////////////////////////////////////

  assign egr_ready      = (egr_q == FILL);
  assign host_out.valid = (egr_q != FILL);
  assign host_out.data  = (egr_q == SEND_LEN) ? 16'(egr_cnt_q) : pkt_mem[rd_q];

  // Packet store
  always_ff @(posedge clk) begin
    if (egr_q == FILL && egr_flit.valid && egr_cnt_q < CW'(MAX)) begin
      pkt_mem[egr_cnt_q[AW-1:0]] <= egr_flit.data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      egr_q     <= FILL;
      egr_cnt_q <= '0;
      rd_q      <= '0;
    end else begin
      case (egr_q)
        FILL: begin
          if (egr_flit.valid) begin
            // Extra words are dropped
            if (egr_cnt_q < CW'(MAX)) begin
              egr_cnt_q <= egr_cnt_q + 1'b1;
            end
            if (egr_flit.last) begin
              egr_q <= SEND_LEN;
            end
          end
        end
        SEND_LEN: begin
          if (host_out_ready) begin
            egr_q <= SEND_DATA;
            rd_q  <= '0;
          end
        end
        SEND_DATA: begin
          if (host_out_ready) begin
            if (CW'(rd_q) + 1'b1 == egr_cnt_q) begin
              egr_q     <= FILL;
              egr_cnt_q <= '0;
            end else begin
              rd_q <= rd_q + 1'b1;
            end
          end
        end
        default: egr_q <= FILL;
      endcase
    end
  end

  // Gateway sent a packet longer than the store
  a_egr_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (egr_q == FILL && egr_flit.valid) |-> (egr_cnt_q < CW'(MAX)));

endmodule

// File: hw/dbg_subnet_ctrl.sv
// Subnet control module with ID registers and reset control
`timescale 1ns/1ps
`include "dbg_soc_defs.svh"

module dbg_subnet_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  dbg_soc_pkg::dbg_flit_t req,
  output logic                   req_ready,
  output dbg_soc_pkg::dbg_flit_t rsp,
  input  logic                   rsp_ready,
  output logic                   sys_rst,
  output logic                   cpu_rst
);
  import dbg_soc_pkg::*;

  // Module header of the control module itself
  localparam logic [15:0] MOD_VENDOR_ID  = 16'h0001;
  localparam logic [15:0] MOD_TYPE_ID    = 16'h0001;
  localparam logic [15:0] MOD_VERSION_ID = 16'h0000;

  typedef enum logic [2:0] {DEST, SRC, FLAGS, ADDR, DATA, RESPOND, DRAIN} state_e;

  state_e        state_q;
  logic [15:0]   src_q;
  logic [15:0]   addr_q;
  logic [15:0]   data_q;
  dbg_pkt_type_e type_q;
  logic          short_q;
  logic          has_data_q;
  logic [1:0]    rst_ctrl_q;
  logic [2:0]    rsp_cnt_q;
  logic          req_acc;
  logic          addr_ok;
  logic          read_only;
  logic [15:0]   rd_data;
  dbg_pkt_type_e rsp_type;

  assign req_ready = (state_q != RESPOND);
  assign req_acc   = req.valid && req_ready;

  //////////////////////////////////////////////////
  // Request collection
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (req_acc) begin
      case (state_q)
        DEST:  addr_q <= '0;
        SRC:   src_q <= req.data;
        FLAGS: type_q <= dbg_pkt_type_e'(req.data[15:12]);
        ADDR:  addr_q <= req.data;
        DATA:  data_q <= req.data;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= DEST;
      short_q    <= 1'b0;
      has_data_q <= 1'b0;
      rst_ctrl_q <= '0;
      rsp_cnt_q  <= '0;
    end else begin
      case (state_q)
        DEST, SRC, FLAGS: begin
          if (req_acc) begin
            // Under four flits
            if (req.last) begin
              short_q    <= 1'b1;
              has_data_q <= 1'b0;
              state_q    <= RESPOND;
            end else begin
              state_q <= state_e'(state_q + 3'd1);
            end
          end
        end
        ADDR: begin
          if (req_acc) begin
            short_q    <= 1'b0;
            has_data_q <= 1'b0;
            state_q    <= req.last ? RESPOND : DATA;
          end
        end
        DATA: begin
          if (req_acc) begin
            has_data_q <= 1'b1;
            state_q    <= req.last ? RESPOND : DRAIN;
          end
        end
        DRAIN: begin
          // Trailing words ignored
          if (req_acc && req.last) begin
            state_q <= RESPOND;
          end
        end
        RESPOND: begin
          if (rsp_ready) begin
            rsp_cnt_q <= rsp_cnt_q + 3'd1;
            if (rsp.last) begin
              rsp_cnt_q <= '0;
              state_q   <= DEST;
              // Write lands once the answer is out
              if (rsp_type == RESP_WRITE) begin
                rst_ctrl_q <= data_q[1:0];
              end
            end
          end
        end
        default: state_q <= DEST;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Register decode and response
  //////////////////////////////////////////////////

  always_comb begin
    rd_data   = '0;
    addr_ok   = 1'b1;
    read_only = 1'b1;
    case (addr_q)
      MOD_VENDOR:  rd_data = MOD_VENDOR_ID;
      MOD_TYPE:    rd_data = MOD_TYPE_ID;
      MOD_VERSION: rd_data = MOD_VERSION_ID;
      SYS_VENDOR:  rd_data = `DBG_SYSTEM_VENDOR_ID;
      SYS_DEVICE:  rd_data = `DBG_SYSTEM_DEVICE_ID;
      SYS_NUM_MOD: rd_data = `DBG_NUM_MODULES;
      SYS_MAX_PKT: rd_data = 16'(`DBG_MAX_PKT_LEN);
      SYS_RST_CTRL: begin
        rd_data   = {14'h0, rst_ctrl_q};
        read_only = 1'b0;
      end
      default: addr_ok = 1'b0;
    endcase

    // Bad length, address, type or target all answer with an error
    if (short_q || !addr_ok) begin
      rsp_type = RESP_ERROR;
    end else if (type_q == REQ_READ) begin
      rsp_type = RESP_READ;
    end else if (type_q == REQ_WRITE && has_data_q && !read_only) begin
      rsp_type = RESP_WRITE;
    end else begin
      rsp_type = RESP_ERROR;
    end
  end

  // Dest, source 0, flags, address, then read data
  always_comb begin
    rsp.valid = (state_q == RESPOND);
    rsp.last  = rsp_cnt_q == ((rsp_type == RESP_READ) ? 3'd4 : 3'd3);
    case (rsp_cnt_q)
      3'd0:    rsp.data = src_q;
      3'd1:    rsp.data = 16'h0000;
      3'd2:    rsp.data = {rsp_type, 12'h000};
      3'd3:    rsp.data = addr_q;
      default: rsp.data = rd_data;
    endcase
  end

  assign sys_rst = rst_ctrl_q[0];
  assign cpu_rst = rst_ctrl_q[1];

  // Stalled response flit stays put
  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp.valid && !rsp_ready) |=> (rsp.valid && $stable(rsp.data) && $stable(rsp.last)));

endmodule

// File: hw/dbg_soc_interface.sv
// Debug subnet top with host interface, ring gateway and control module
`timescale 1ns/1ps

module dbg_soc_interface (
  input  logic                    clk,
  input  logic                    rst_n,
  input  dbg_soc_pkg::host_word_t host_in,
  output logic                    host_in_ready,
  output dbg_soc_pkg::host_word_t host_out,
  input  logic                    host_out_ready,
  input  dbg_soc_pkg::dbg_flit_t  ring_in,
  output logic                    ring_in_ready,
  output dbg_soc_pkg::dbg_flit_t  ring_out,
  input  logic                    ring_out_ready,
  output logic                    sys_rst,
  output logic                    cpu_rst
);
  import dbg_soc_pkg::*;

  // Host side links
  dbg_flit_t him_ing;
  logic      him_ing_ready;
  dbg_flit_t him_egr;
  logic      him_egr_ready;

  // Control module links
  dbg_flit_t scm_req;
  logic      scm_req_ready;
  dbg_flit_t scm_rsp;
  logic      scm_rsp_ready;

  dbg_host_if i_host_if (
    .clk            (clk),
    .rst_n          (rst_n),
    .host_in        (host_in),
    .host_in_ready  (host_in_ready),
    .host_out       (host_out),
    .host_out_ready (host_out_ready),
    .ing_flit       (him_ing),
    .ing_ready      (him_ing_ready),
    .egr_flit       (him_egr),
    .egr_ready      (him_egr_ready)
  );

  // Gateway sits at local id 0
  dbg_ring_gateway i_gateway (
    .clk             (clk),
    .rst_n           (rst_n),
    .ring_in         (ring_in),
    .local_in        (scm_rsp),
    .ext_in          (him_ing),
    .ring_in_ready   (ring_in_ready),
    .local_in_ready  (scm_rsp_ready),
    .ext_in_ready    (him_ing_ready),
    .ring_out        (ring_out),
    .local_out       (scm_req),
    .ext_out         (him_egr),
    .ring_out_ready  (ring_out_ready),
    .local_out_ready (scm_req_ready),
    .ext_out_ready   (him_egr_ready)
  );

  dbg_subnet_ctrl i_subnet_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (scm_req),
    .req_ready (scm_req_ready),
    .rsp       (scm_rsp),
    .rsp_ready (scm_rsp_ready),
    .sys_rst   (sys_rst),
    .cpu_rst   (cpu_rst)
  );

endmodule

// File: tests/tb_dbg_tasks.svh
// Timeout handling, word and flit queue pops, send, receive and compare tasks
`ifndef TB_DBG_TASKS_SVH
`define TB_DBG_TASKS_SVH

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

task automatic fail_timeout(input string what);
  $display("Timeout: no handshake on %s within %0d cycles", what, TIMEOUT);
  $display("Simulation failed");
  $fatal(1, "handshake timeout");
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("** Error [%s] bit expected %b actual %b", name, exp, act);
    $display("Simulation failed");
    $fatal(1, "bit mismatch");
  end
endtask

task automatic check_flit(input string name, input dbg_flit_t exp, input dbg_flit_t act);
  if (act !== exp) begin
    $display("** Error [%s] flit expected %h actual %h", name, exp, act);
    $display("Simulation failed");
    $fatal(1, "flit mismatch");
  end
endtask

task automatic check_word(input string name, input host_word_t exp, input host_word_t act);
  if (act !== exp) begin
    $display("** Error [%s] word expected %h actual %h", name, exp, act);
    $display("Simulation failed");
    $fatal(1, "word mismatch");
  end
endtask

task automatic check_type(input string name, input dbg_pkt_type_e exp,
                          input dbg_pkt_type_e act);
  if (act !== exp) begin
    $display("** Error [%s] type expected %h actual %h", name, exp, act);
    $display("Simulation failed");
    $fatal(1, "type mismatch");
  end
endtask

//////////////////////////////////////////////////
// Senders, called 1 ns after a rising edge
//////////////////////////////////////////////////

task automatic host_send_word(input logic [15:0] data);
  int n = 0;
  host_in.valid = 1'b1;
  host_in.data  = data;
  // Ready seen before the edge means the word goes at that edge
  @(negedge clk);
  while (!host_in_ready) begin
    n++;
    if (n > TIMEOUT) fail_timeout("host_in");
    @(negedge clk);
  end
  @(posedge clk);
  #1;
  host_in.valid = 1'b0;
endtask

task automatic host_send_pkt(input word_q_t words);
  // Length prefix, then the flits
  host_send_word(16'(words.size()));
  foreach (words[i]) host_send_word(words[i]);
endtask

task automatic ring_send_pkt(input word_q_t words);
  int n;
  foreach (words[i]) begin
    n = 0;
    ring_in.valid = 1'b1;
    ring_in.last  = (i == words.size() - 1);
    ring_in.data  = words[i];
    @(negedge clk);
    while (!ring_in_ready) begin
      n++;
      if (n > TIMEOUT) fail_timeout("ring_in");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    ring_in.valid = 1'b0;
  end
endtask

//////////////////////////////////////////////////
// Receivers, fed by the output monitors
//////////////////////////////////////////////////

task automatic pop_host_word(output host_word_t w);
  int n = 0;
  while (host_q.size() == 0) begin
    n++;
    if (n > TIMEOUT) fail_timeout("host_out");
    @(negedge clk);
  end
  w = host_q.pop_front();
endtask

task automatic pop_ring_flit(output dbg_flit_t f);
  int n = 0;
  while (ring_q.size() == 0) begin
    n++;
    if (n > TIMEOUT) fail_timeout("ring_out");
    @(negedge clk);
  end
  f = ring_q.pop_front();
endtask

task automatic host_recv_pkt(input string name, input word_q_t exp);
  host_word_t w;
  host_word_t e;
  pop_host_word(w);
  e = '{valid: 1'b1, data: 16'(exp.size())};
  check_word({name, " length"}, e, w);
  foreach (exp[i]) begin
    pop_host_word(w);
    // Flags word carries the packet type
    if (i == 2) check_type(name, dbg_pkt_type_e'(exp[i][15:12]), dbg_pkt_type_e'(w.data[15:12]));
    e = '{valid: 1'b1, data: exp[i]};
    check_word(name, e, w);
  end
  @(posedge clk);
  #1;
endtask

task automatic ring_recv_pkt(input string name, input word_q_t exp);
  dbg_flit_t f;
  dbg_flit_t e;
  foreach (exp[i]) begin
    pop_ring_flit(f);
    if (i == 2) check_type(name, dbg_pkt_type_e'(exp[i][15:12]), dbg_pkt_type_e'(f.data[15:12]));
    e = '{valid: 1'b1, last: (i == exp.size() - 1), data: exp[i]};
    check_flit(name, e, f);
  end
  @(posedge clk);
  #1;
endtask

`endif

// File: tests/tb_dbg_soc_interface.sv
// Testbench for the debug subnet top with host and ring models and directed tests
`timescale 1ns/1ps
`include "dbg_soc_defs.svh"

module tb_dbg_soc_interface;
  import dbg_soc_pkg::*;

  typedef logic [15:0] word_q_t [$];

  localparam int TIMEOUT = 2000;
  // Control module, subnet 0 id 0
  localparam logic [15:0] CTRL_DEST = 16'h0000;
  // Host sits on foreign subnet 1
  localparam logic [15:0] HOST_SRC = 16'h0400;

  logic       clk;
  logic       rst_n;
  host_word_t host_in;
  logic       host_in_ready;
  host_word_t host_out;
  logic       host_out_ready;
  dbg_flit_t  ring_in;
  logic       ring_in_ready;
  dbg_flit_t  ring_out;
  logic       ring_out_ready;
  logic       sys_rst;
  logic       cpu_rst;

  // Words and flits taken by the host and ring models
  host_word_t host_q [$];
  dbg_flit_t  ring_q [$];

  `include "tb_dbg_tasks.svh"

  dbg_soc_interface i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .host_in        (host_in),
    .host_in_ready  (host_in_ready),
    .host_out       (host_out),
    .host_out_ready (host_out_ready),
    .ring_in        (ring_in),
    .ring_in_ready  (ring_in_ready),
    .ring_out       (ring_out),
    .ring_out_ready (ring_out_ready),
    .sys_rst        (sys_rst),
    .cpu_rst        (cpu_rst)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Random back-pressure on both outputs
  initial begin
    void'($urandom(32'h542a));
    host_out_ready = 1'b0;
    ring_out_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      host_out_ready = ($urandom % 4) != 0;
      ring_out_ready = ($urandom % 4) != 0;
    end
  end

  // Handshake seen mid-cycle completes at the next edge
  always @(negedge clk) begin
    if (rst_n && host_out.valid && host_out_ready) begin
      host_q.push_back(host_out);
    end
    if (rst_n && ring_out.valid && ring_out_ready) begin
      ring_q.push_back(ring_out);
    end
  end

  //////////////////////////////////////////////////
  // Packet builders
  //////////////////////////////////////////////////

  // Response back to the source, own source field 0
  function automatic word_q_t rsp_words(logic [15:0] dst, dbg_pkt_type_e typ,
                                        logic [15:0] addr, logic [15:0] data);
    word_q_t q;
    q = '{dst, 16'h0000, {typ, 12'h000}, addr};
    if (typ == RESP_READ) q.push_back(data);
    return q;
  endfunction

  task automatic host_request(input dbg_pkt_type_e typ, input logic [15:0] addr,
                              input logic [15:0] data);
    word_q_t req;
    req = '{CTRL_DEST, HOST_SRC, {typ, 12'h000}, addr};
    // Data word only on writes
    if (typ == REQ_WRITE) req.push_back(data);
    host_send_pkt(req);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset_state();
    check_bit("reset host_out valid", 1'b0, host_out.valid);
    check_bit("reset ring_out valid", 1'b0, ring_out.valid);
    check_bit("reset sys_rst", 1'b0, sys_rst);
    check_bit("reset cpu_rst", 1'b0, cpu_rst);
  endtask

  task automatic test_id_reads();
    // Two requests in a row, answers must keep their order
    host_request(REQ_READ, SYS_VENDOR, 16'h0);
    host_request(REQ_READ, SYS_DEVICE, 16'h0);
    host_recv_pkt("id vendor", rsp_words(HOST_SRC, RESP_READ, SYS_VENDOR, `DBG_SYSTEM_VENDOR_ID));
    host_recv_pkt("id device", rsp_words(HOST_SRC, RESP_READ, SYS_DEVICE, `DBG_SYSTEM_DEVICE_ID));
    host_request(REQ_READ, SYS_NUM_MOD, 16'h0);
    host_recv_pkt("id num_mod", rsp_words(HOST_SRC, RESP_READ, SYS_NUM_MOD, `DBG_NUM_MODULES));
    host_request(REQ_READ, SYS_MAX_PKT, 16'h0);
    host_recv_pkt("id max_pkt",
                  rsp_words(HOST_SRC, RESP_READ, SYS_MAX_PKT, 16'(`DBG_MAX_PKT_LEN)));
  endtask

  task automatic test_rst_ctrl();
    host_request(REQ_WRITE, SYS_RST_CTRL, 16'h0003);
    host_recv_pkt("rst set", rsp_words(HOST_SRC, RESP_WRITE, SYS_RST_CTRL, 16'h0));
    check_bit("rst set sys_rst", 1'b1, sys_rst);
    check_bit("rst set cpu_rst", 1'b1, cpu_rst);
    host_request(REQ_READ, SYS_RST_CTRL, 16'h0);
    host_recv_pkt("rst read", rsp_words(HOST_SRC, RESP_READ, SYS_RST_CTRL, 16'h0003));
    host_request(REQ_WRITE, SYS_RST_CTRL, 16'h0000);
    host_recv_pkt("rst clear", rsp_words(HOST_SRC, RESP_WRITE, SYS_RST_CTRL, 16'h0));
    check_bit("rst clear sys_rst", 1'b0, sys_rst);
    check_bit("rst clear cpu_rst", 1'b0, cpu_rst);
  endtask

  task automatic test_errors();
    host_request(REQ_READ, 16'h0300, 16'h0);
    host_recv_pkt("err unknown", rsp_words(HOST_SRC, RESP_ERROR, 16'h0300, 16'h0));
    host_request(REQ_WRITE, SYS_VENDOR, 16'h1234);
    host_recv_pkt("err read-only", rsp_words(HOST_SRC, RESP_ERROR, SYS_VENDOR, 16'h0));
    // No address flit, reported as address 0
    host_send_pkt('{CTRL_DEST, HOST_SRC, {REQ_READ, 12'h000}});
    host_recv_pkt("err short", rsp_words(HOST_SRC, RESP_ERROR, 16'h0000, 16'h0));
  endtask

  task automatic test_routing();
    word_q_t pkt;
    // Local subnet, id 5 lives on the ring
    pkt = '{16'h0005, HOST_SRC, 16'h1234, 16'hbeef};
    host_send_pkt(pkt);
    ring_recv_pkt("route host to ring", pkt);
    // Subnet 3 is reached through the host
    pkt = '{16'h0c02, 16'h0007, 16'h5a5a, 16'h0001, 16'h00ff};
    ring_send_pkt(pkt);
    host_recv_pkt("route ring to host", pkt);
    // Ring module at id 7 asks the control module
    ring_send_pkt('{CTRL_DEST, 16'h0007, {REQ_READ, 12'h000}, SYS_DEVICE});
    ring_recv_pkt("route ring read",
                  rsp_words(16'h0007, RESP_READ, SYS_DEVICE, `DBG_SYSTEM_DEVICE_ID));
  endtask

  task automatic check_quiet(input string name);
    if (host_q.size() != 0 || ring_q.size() != 0) begin
      $display("[%s] unexpected traffic left over: %0d host words, %0d ring flits",
               name, host_q.size(), ring_q.size());
      $display("Simulation failed");
      $fatal(1, "leftover traffic");
    end
  endtask

  initial begin
    rst_n   = 1'b0;
    host_in = '0;
    ring_in = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    test_reset_state();
    test_id_reads();
    test_rst_ctrl();
    test_errors();
    test_routing();
    check_quiet("end of tests");
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: list.f
+incdir+hw
+incdir+tests
hw/dbg_soc_pkg.sv
hw/dbg_pkt_arbiter.sv
hw/dbg_ring_gateway.sv
hw/dbg_host_if.sv
hw/dbg_subnet_ctrl.sv
hw/dbg_soc_interface.sv
tests/tb_dbg_soc_interface.sv

// File: Bender.yml
package:
  name: dbg_soc_interface

sources:
  - include_dirs:
      - hw
    files:
      - hw/dbg_soc_pkg.sv
      - hw/dbg_pkt_arbiter.sv
      - hw/dbg_ring_gateway.sv
      - hw/dbg_host_if.sv
      - hw/dbg_subnet_ctrl.sv
      - hw/dbg_soc_interface.sv
  - target: test
    include_dirs:
      - hw
      - tests
    files:
      - tests/tb_dbg_soc_interface.sv
